/* logic/lumi_cfg_pkg.sv */
//######################################################################
// Receive link geometry with the tagged beat format used by the buffer
//######################################################################
`default_nettype none

package lumi_cfg_pkg;

   localparam int LINK_W = 16;             // PHY beat width
   localparam int CRDT_W = 16;             // Credit counter width

   // Packet class carried with every beat
   typedef enum logic [1:0] {
      TAG_REQ  = 2'd0,                     // Read or write request
      TAG_RESP = 2'd1,                     // Read or write response
      TAG_LINK = 2'd2,                     // Credit update, never forwarded
      TAG_DROP = 2'd3                      // Invalid opcode
   } beat_tag_t;

   // One buffered beat, 19 bits
   typedef struct packed {
      logic [LINK_W-1:0] data;             // Raw link beat
      logic              eop;              // Last beat of packet
      beat_tag_t         tag;              // Class of owning packet
   } rx_beat_t;

endpackage

`default_nettype wire

/* logic/lumi_cmd_pkg.sv */
//######################################################################
// Command word decode views, opcodes and reassembled packet format
//######################################################################
`default_nettype none

package lumi_cmd_pkg;

   localparam int CMD_W  = 32;
   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;

   // Supported opcodes, anything else is dropped
   typedef enum logic [3:0] {
      OPC_READ_REQ   = 4'd1,
      OPC_WRITE_REQ  = 4'd2,
      OPC_READ_RESP  = 4'd3,
      OPC_WRITE_RESP = 4'd4,
      OPC_LINK       = 4'd7
   } opcode_t;

   // Normal transaction view
   typedef struct packed {
      logic [25:0] rsvd;
      logic [1:0]  len;                    // Data words minus one
      logic [3:0]  opcode;
   } umi_cmd_t;

   // Link command view
   typedef struct packed {
      logic [15:0] crdt_val;               // New remote credit value
      logic [7:0]  rsvd;
      logic [3:0]  crdt_sel;               // Which credit counter
      logic [3:0]  opcode;
   } link_cmd_t;

   // Same 32-bit word, two decodes
   typedef union packed {
      umi_cmd_t  umi;
      link_cmd_t link;
   } cmd_word_u;

   localparam logic [3:0] CRDT_SEL_REQ  = 4'd1;
   localparam logic [3:0] CRDT_SEL_RESP = 4'd2;

   // Reassembled packet, cmd sits in the low bits like on the link
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [ADDR_W-1:0] srcaddr;
      logic [ADDR_W-1:0] dstaddr;
      logic [CMD_W-1:0]  cmd;
   } umi_pkt_t;

   //###################################################################
   // Packet lengths in link beats
   //###################################################################
   localparam int BEAT_CNT_W = 4;          // Longest packet is 10 beats

   localparam logic [BEAT_CNT_W-1:0] HDR_ONLY_BEATS = 4'd2;   // Link and invalid
   localparam logic [BEAT_CNT_W-1:0] NODATA_BEATS   = 4'd6;   // Cmd plus both addresses

endpackage

`default_nettype wire

/* logic/link_framer.sv */
//######################################################################
// Receive framer that samples PHY beats and tags each one by class
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module link_framer (
   input  logic                            clk,
   input  logic                            nreset,
   input  logic [lumi_cfg_pkg::LINK_W-1:0] phy_rxdata,
   input  logic                            phy_rxvld,
   output logic                            wr_en,
   output lumi_cfg_pkg::rx_beat_t          wr_beat
);
   import lumi_cfg_pkg::*;
   import lumi_cmd_pkg::*;

   logic                  rxvalid;         // Registered PHY valid
   logic [LINK_W-1:0]     rxdata;          // Registered PHY beat
   cmd_word_u             hdr;             // First beat seen as a command word
   logic [BEAT_CNT_W-1:0] data_beats;
   logic [BEAT_CNT_W-1:0] len_raw;
   logic [BEAT_CNT_W-1:0] len_hold;
   logic [BEAT_CNT_W-1:0] pkt_beats;
   logic [BEAT_CNT_W-1:0] beat_cnt;
   logic [BEAT_CNT_W-1:0] beat_cnt_nxt;
   beat_tag_t             tag_raw;
   beat_tag_t             tag_hold;
   logic                  sop;
   logic                  eop;

   //###################################################################
   // Input sampling
   //###################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         rxvalid <= 1'b0;
      else
         rxvalid <= phy_rxvld;

   always_ff @(posedge clk)
      rxdata <= phy_rxdata;

   //###################################################################
   // Header decode on first beat
   //###################################################################
   // Only opcode and len live in the low beat
   assign hdr        = {{(CMD_W-LINK_W){1'b0}}, rxdata};
   assign data_beats = BEAT_CNT_W'(hdr.umi.len) + 1'b1;

   always_comb
   begin
      len_raw = HDR_ONLY_BEATS;            // Invalid opcodes by default
      tag_raw = TAG_DROP;
      case (hdr.umi.opcode)
         OPC_READ_REQ:
         begin
            len_raw = NODATA_BEATS;
            tag_raw = TAG_REQ;
         end
         OPC_WRITE_REQ:
         begin
            len_raw = NODATA_BEATS + data_beats;
            tag_raw = TAG_REQ;
         end
         OPC_READ_RESP:
         begin
            len_raw = NODATA_BEATS + data_beats;
            tag_raw = TAG_RESP;
         end
         OPC_WRITE_RESP:
         begin
            len_raw = NODATA_BEATS;
            tag_raw = TAG_RESP;
         end
         OPC_LINK:
            tag_raw = TAG_LINK;            // Cmd only
         default:
            tag_raw = TAG_DROP;
      endcase
   end

   //###################################################################
   // Start of packet tracking
   //###################################################################
   assign sop          = (beat_cnt == '0);
   assign pkt_beats    = sop ? len_raw : len_hold;
   assign beat_cnt_nxt = beat_cnt + 1'b1;
   assign eop          = (beat_cnt_nxt == pkt_beats);

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         beat_cnt <= '0;
         len_hold <= HDR_ONLY_BEATS;
         tag_hold <= TAG_DROP;
      end
      else if (rxvalid)
      begin
         beat_cnt <= eop ? '0 : beat_cnt_nxt;   // Wrap at packet end
         if (sop)
         begin
            len_hold <= len_raw;           // Held for rest of packet
            tag_hold <= tag_raw;
         end
      end

   // Tagged beat straight into the buffer
   assign wr_en = rxvalid;

   always_comb
   begin
      wr_beat.data = rxdata;
      wr_beat.eop  = eop;
      wr_beat.tag  = sop ? tag_raw : tag_hold;
   end

endmodule

`default_nettype wire

/* logic/rx_beat_fifo.sv */
//######################################################################
// Circular receive buffer of tagged beats with empty and full flags
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module rx_beat_fifo #(
   parameter int FIFO_DEPTH = 16           // Depth in beats
) (
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   wr_en,
   input  lumi_cfg_pkg::rx_beat_t wr_beat,
   input  logic                   rd_en,
   output lumi_cfg_pkg::rx_beat_t rd_beat,
   output logic                   empty,
   output logic                   full
);
   import lumi_cfg_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   rx_beat_t         mem [FIFO_DEPTH];     // Beat storage
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;                // Occupancy
   logic             do_wr;
   logic             do_rd;

   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   // Storage write
   always_ff @(posedge clk)
      if (do_wr)
         mem[wr_ptr] <= wr_beat;

   // Pointers wrap at depth, not only at powers of two
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end

   assign rd_beat = mem[rd_ptr];           // Head of queue, no read latency
   assign empty   = (count == '0);
   assign full    = (count == (PTR_W+1)'(FIFO_DEPTH));

endmodule

`default_nettype wire

/* logic/packet_assembler.sv */
//######################################################################
// Packet reassembly from buffered beats with routing and credit tracking
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module packet_assembler (
   input  logic                            clk,
   input  logic                            nreset,
   input  logic                            csr_en,
   input  logic [lumi_cfg_pkg::CRDT_W-1:0] crdt_init,
   input  lumi_cfg_pkg::rx_beat_t          rd_beat,
   input  logic                            empty,
   output logic                            rd_en,
   output lumi_cmd_pkg::umi_pkt_t          req_out,
   output logic                            req_valid,
   input  logic                            req_ready,
   output lumi_cmd_pkg::umi_pkt_t          resp_out,
   output logic                            resp_valid,
   input  logic                            resp_ready,
   output logic [lumi_cfg_pkg::CRDT_W-1:0] loc_crdt,
   output logic [lumi_cfg_pkg::CRDT_W-1:0] rmt_crdt_req,
   output logic [lumi_cfg_pkg::CRDT_W-1:0] rmt_crdt_resp
);
   import lumi_cfg_pkg::*;
   import lumi_cmd_pkg::*;

   localparam int PKT_W      = $bits(umi_pkt_t);
   localparam int DATA_WORDS = DATA_W / LINK_W;

   logic [BEAT_CNT_W-1:0] beat_idx;        // Slot of next popped beat
   logic [PKT_W-1:0]      shift_q;         // Beats gathered so far
   logic [PKT_W-1:0]      asm_vec;         // Gathered beats plus current one
   umi_pkt_t              asm_pkt;
   umi_pkt_t              pkt_clean;
   cmd_word_u             asm_cmd;
   logic                  no_data;
   logic                  hdr_only;
   logic                  req_free;
   logic                  resp_free;
   logic                  slot_free;
   logic                  pop_eop;

   //###################################################################
   // Pop control
   //###################################################################
   assign req_free  = ~req_valid | req_ready;     // Empty or leaving now
   assign resp_free = ~resp_valid | resp_ready;

   // Only the last beat needs a free output register
   always_comb
      case (rd_beat.tag)
         TAG_REQ:  slot_free = req_free;
         TAG_RESP: slot_free = resp_free;
         default:  slot_free = 1'b1;        // Link and drop never stall
      endcase

   assign rd_en   = ~empty & (~rd_beat.eop | slot_free);
   assign pop_eop = rd_en & rd_beat.eop;

   //###################################################################
   // Reassembly
   //###################################################################
   always_comb
   begin
      asm_vec = shift_q;
      asm_vec[beat_idx*LINK_W +: LINK_W] = rd_beat.data;
   end

   assign asm_pkt  = umi_pkt_t'(asm_vec);
   assign asm_cmd  = asm_pkt.cmd;
   assign no_data  = (asm_cmd.umi.opcode == OPC_READ_REQ) |
                     (asm_cmd.umi.opcode == OPC_WRITE_RESP);
   assign hdr_only = (rd_beat.tag == TAG_LINK) | (rd_beat.tag == TAG_DROP);

   // Clear whatever the packet class leaves stale
   always_comb
   begin
      pkt_clean = asm_pkt;
      for (int i = 0; i < DATA_WORDS; i++)
      begin
         if (no_data || (i > int'(asm_cmd.umi.len)))
            pkt_clean.data[i*LINK_W +: LINK_W] = '0;   // Past len
      end
      if (hdr_only)
      begin
         pkt_clean.dstaddr = '0;
         pkt_clean.srcaddr = '0;
         pkt_clean.data    = '0;
      end
   end

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         beat_idx <= '0;
      else if (rd_en)
         beat_idx <= rd_beat.eop ? '0 : beat_idx + 1'b1;

   always_ff @(posedge clk)
      if (rd_en)
         shift_q <= asm_vec;

   //###################################################################
   // Output registers
   //###################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         req_valid  <= 1'b0;
         resp_valid <= 1'b0;
      end
      else
      begin
         if (pop_eop && rd_beat.tag == TAG_REQ)
            req_valid <= 1'b1;
         else if (req_ready)
            req_valid <= 1'b0;
         if (pop_eop && rd_beat.tag == TAG_RESP)
            resp_valid <= 1'b1;
         else if (resp_ready)
            resp_valid <= 1'b0;
      end

   always_ff @(posedge clk)
   begin
      if (pop_eop && rd_beat.tag == TAG_REQ)
         req_out <= pkt_clean;
      if (pop_eop && rd_beat.tag == TAG_RESP)
         resp_out <= pkt_clean;
   end

   //###################################################################
   // Credits
   //###################################################################
   // Remote values taken from link commands
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         rmt_crdt_req  <= '0;
         rmt_crdt_resp <= '0;
      end
      else if (pop_eop && rd_beat.tag == TAG_LINK)
      begin
         if (asm_cmd.link.crdt_sel == CRDT_SEL_REQ)
            rmt_crdt_req <= asm_cmd.link.crdt_val;
         else if (asm_cmd.link.crdt_sel == CRDT_SEL_RESP)
            rmt_crdt_resp <= asm_cmd.link.crdt_val;
      end

   // Local credits, one per consumed beat
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         loc_crdt <= '0;
      else if (!csr_en)
         loc_crdt <= crdt_init;            // Load while disabled
      else if (rd_en)
         loc_crdt <= loc_crdt + 1'b1;

endmodule

`default_nettype wire

/* logic/lumi_rx_top.sv */
//######################################################################
// Link receiver top joining framer, beat buffer and packet assembler
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module lumi_rx_top #(
   parameter int FIFO_DEPTH = 16           // Receive buffer depth in beats
) (
   input  logic                            clk,
   input  logic                            nreset,
   input  logic                            csr_en,
   input  logic [lumi_cfg_pkg::CRDT_W-1:0] crdt_init,
   input  logic [lumi_cfg_pkg::LINK_W-1:0] phy_rxdata,
   input  logic                            phy_rxvld,
   output lumi_cmd_pkg::umi_pkt_t          req_out,
   output logic                            req_valid,
   input  logic                            req_ready,
   output lumi_cmd_pkg::umi_pkt_t          resp_out,
   output logic                            resp_valid,
   input  logic                            resp_ready,
   output logic [lumi_cfg_pkg::CRDT_W-1:0] loc_crdt,
   output logic [lumi_cfg_pkg::CRDT_W-1:0] rmt_crdt_req,
   output logic [lumi_cfg_pkg::CRDT_W-1:0] rmt_crdt_resp
);
   import lumi_cfg_pkg::*;

   logic     fifo_wr_en;                   // Framer push
   rx_beat_t fifo_wr_beat;
   logic     fifo_rd_en;                   // Assembler pop
   rx_beat_t fifo_rd_beat;
   logic     fifo_empty;
   logic     fifo_full;                    // Watched for overflow only

   // PHY sampling and tagging
   link_framer link_framer_i (
      .clk        (clk),
      .nreset     (nreset),
      .phy_rxdata (phy_rxdata),
      .phy_rxvld  (phy_rxvld),
      .wr_en      (fifo_wr_en),
      .wr_beat    (fifo_wr_beat)
   );

   // Shared beat buffer
   rx_beat_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) rx_beat_fifo_i (
      .clk     (clk),
      .nreset  (nreset),
      .wr_en   (fifo_wr_en),
      .wr_beat (fifo_wr_beat),
      .rd_en   (fifo_rd_en),
      .rd_beat (fifo_rd_beat),
      .empty   (fifo_empty),
      .full    (fifo_full)
   );

   // Reassembly, routing and credits
   packet_assembler packet_assembler_i (
      .clk           (clk),
      .nreset        (nreset),
      .csr_en        (csr_en),
      .crdt_init     (crdt_init),
      .rd_beat       (fifo_rd_beat),
      .empty         (fifo_empty),
      .rd_en         (fifo_rd_en),
      .req_out       (req_out),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .resp_out      (resp_out),
      .resp_valid    (resp_valid),
      .resp_ready    (resp_ready),
      .loc_crdt      (loc_crdt),
      .rmt_crdt_req  (rmt_crdt_req),
      .rmt_crdt_resp (rmt_crdt_resp)
   );

endmodule

`default_nettype wire

/* verif/lumi_rx_assertions.sv */
//######################################################################
// Protocol checks on the link receiver, bound to its top level
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module lumi_rx_assertions (
   input  logic                            clk,
   input  logic                            nreset,
   input  lumi_cmd_pkg::umi_pkt_t          req_out,
   input  logic                            req_valid,
   input  logic                            req_ready,
   input  lumi_cmd_pkg::umi_pkt_t          resp_out,
   input  logic                            resp_valid,
   input  logic                            resp_ready,
   input  logic                            fifo_wr_en,
   input  logic                            fifo_full,
   input  logic                            fifo_rd_en,
   input  logic [lumi_cfg_pkg::CRDT_W-1:0] loc_crdt,
   input  logic [lumi_cfg_pkg::CRDT_W-1:0] rmt_crdt_req,
   input  logic [lumi_cfg_pkg::CRDT_W-1:0] rmt_crdt_resp
);

   // Request held until taken
   req_hold: assert property (@(posedge clk) disable iff (!nreset)
      req_valid && !req_ready |=> req_valid && $stable(req_out))
      else $error("req_valid or req_out changed before req_ready");

   // Response held until taken
   resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_out))
      else $error("resp_valid or resp_out changed before resp_ready");

   // Framer never pushes into a full buffer
   no_overflow: assert property (@(posedge clk) disable iff (!nreset)
      fifo_wr_en |-> !fifo_full)
      else $error("beat buffer written while full");

   // Everything quiet out of reset
   reset_idle: assert property (@(posedge clk)
      !nreset |=> !req_valid && !resp_valid && !fifo_rd_en &&
                  (loc_crdt == '0) && (rmt_crdt_req == '0) && (rmt_crdt_resp == '0))
      else $error("outputs not idle after reset");

endmodule

bind lumi_rx_top lumi_rx_assertions lumi_rx_assertions_i (
   .clk           (clk),
   .nreset        (nreset),
   .req_out       (req_out),
   .req_valid     (req_valid),
   .req_ready     (req_ready),
   .resp_out      (resp_out),
   .resp_valid    (resp_valid),
   .resp_ready    (resp_ready),
   .fifo_wr_en    (fifo_wr_en),
   .fifo_full     (fifo_full),
   .fifo_rd_en    (fifo_rd_en),
   .loc_crdt      (loc_crdt),
   .rmt_crdt_req  (rmt_crdt_req),
   .rmt_crdt_resp (rmt_crdt_resp)
);

`default_nettype wire

/* verif/lumi_rx_tb.sv */
//######################################################################
// Link receiver testbench with packet scoreboard and credit checks
//######################################################################
`timescale 1ns/100ps
`default_nettype none

module lumi_rx_tb;
   import lumi_cfg_pkg::*;
   import lumi_cmd_pkg::*;

   localparam int                FIFO_DEPTH = 16;
   localparam int                NUM_PKTS   = 64;      // Packets over all phases
   localparam int                MAX_CYCLES = 40 * NUM_PKTS * 10 + 200;  // 10 beats max
   localparam logic [CRDT_W-1:0] CRDT_START = 16'd100;

   logic              clk;
   logic              nreset;
   logic              csr_en;
   logic [CRDT_W-1:0] crdt_init;
   logic [LINK_W-1:0] phy_rxdata;
   logic              phy_rxvld;
   umi_pkt_t          req_out;
   logic              req_valid;
   logic              req_ready;
   umi_pkt_t          resp_out;
   logic              resp_valid;
   logic              resp_ready;
   logic [CRDT_W-1:0] loc_crdt;
   logic [CRDT_W-1:0] rmt_crdt_req;
   logic [CRDT_W-1:0] rmt_crdt_resp;

   umi_pkt_t          req_q [$];           // Expected requests, oldest first
   umi_pkt_t          resp_q [$];
   umi_pkt_t          exp_req;
   umi_pkt_t          exp_resp;
   logic [CRDT_W-1:0] exp_rmt_req;
   logic [CRDT_W-1:0] exp_rmt_resp;
   logic [31:0]       stim_state;          // Stimulus random stream
   logic [31:0]       ready_state;         // Ready pattern stream
   logic [31:0]       pick;
   logic              ready_mode;          // Random readies when set
   int                beats_sent;
   int                cycle_cnt;
   string             test_name;

   lumi_rx_top #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) lumi_rx_top_i (
      .clk           (clk),
      .nreset        (nreset),
      .csr_en        (csr_en),
      .crdt_init     (crdt_init),
      .phy_rxdata    (phy_rxdata),
      .phy_rxvld     (phy_rxvld),
      .req_out       (req_out),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .resp_out      (resp_out),
      .resp_valid    (resp_valid),
      .resp_ready    (resp_ready),
      .loc_crdt      (loc_crdt),
      .rmt_crdt_req  (rmt_crdt_req),
      .rmt_crdt_resp (rmt_crdt_resp)
   );

   always #50 clk = ~clk;                  // 100 ns period

   //###################################################################
   // Random numbers and failure reporting
   //###################################################################
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] stim_rand();
      stim_state = xorshift32(stim_state);
      return stim_state;
   endfunction

   task automatic abort_run();
      $display("TB FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_error(input string msg);
      $display("ERROR in %s: %s", test_name, msg);
      abort_run();
   endtask

   task automatic report_mismatch(input string what, input logic [159:0] exp,
                                  input logic [159:0] act);
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
      abort_run();
   endtask

   //###################################################################
   // PHY stimulus
   //###################################################################
   task automatic drive_idle();
      @(posedge clk);
      #10;
      phy_rxvld = 1'b0;
   endtask

   // One beat, after credit wait and an occasional gap
   task automatic send_beat(input logic [LINK_W-1:0] data);
      logic [31:0] r;
      r = stim_rand();
      if (r[1:0] == 2'd0)
         drive_idle();
      while (beats_sent - (int'(loc_crdt) - int'(CRDT_START)) >= FIFO_DEPTH)
         drive_idle();                     // Out of credit
      @(posedge clk);
      #10;
      phy_rxdata = data;
      phy_rxvld  = 1'b1;
      beats_sent = beats_sent + 1;
   endtask

   task automatic send_umi(input logic [3:0] opc, input logic [1:0] len);
      cmd_word_u    cmd;
      umi_pkt_t     pkt;
      logic [159:0] vec;
      logic         has_data;
      int           nbeats;
      has_data       = (opc == OPC_WRITE_REQ) || (opc == OPC_READ_RESP);
      cmd.umi.rsvd   = 26'(stim_rand());
      cmd.umi.len    = len;
      cmd.umi.opcode = opc;
      pkt.cmd        = cmd;
      pkt.dstaddr    = stim_rand();
      pkt.srcaddr    = stim_rand();
      pkt.data       = {stim_rand(), stim_rand()};
      for (int w = 0; w < 4; w++)
         if (!has_data || (w > int'(len)))
            pkt.data[w*LINK_W +: LINK_W] = '0;    // Word never sent
      nbeats = int'(NODATA_BEATS);
      if (has_data)
         nbeats = nbeats + int'(len) + 1;
      vec = pkt;
      if ((opc == OPC_WRITE_REQ) || (opc == OPC_READ_REQ))
         req_q.push_back(pkt);
      else
         resp_q.push_back(pkt);
      for (int b = 0; b < nbeats; b++)
         send_beat(vec[b*LINK_W +: LINK_W]);     // Low word first
   endtask

   task automatic send_link(input logic [3:0] sel, input logic [CRDT_W-1:0] val);
      cmd_word_u   cmd;
      logic [31:0] word;
      cmd.link.crdt_val = val;
      cmd.link.rsvd     = 8'(stim_rand());
      cmd.link.crdt_sel = sel;
      cmd.link.opcode   = OPC_LINK;
      if (sel == CRDT_SEL_REQ)
         exp_rmt_req = val;
      else if (sel == CRDT_SEL_RESP)
         exp_rmt_resp = val;
      word = cmd;
      send_beat(word[15:0]);
      send_beat(word[31:16]);
   endtask

   // Two beats with a random unsupported opcode
   task automatic send_invalid();
      logic [31:0] word;
      word = stim_rand();
      while (word[3:0] inside {OPC_READ_REQ, OPC_WRITE_REQ, OPC_READ_RESP,
                               OPC_WRITE_RESP, OPC_LINK})
         word = stim_rand();
      send_beat(word[15:0]);
      send_beat(word[31:16]);
   endtask

   // Flush framer, then wait for empty buffer and scoreboard
   task automatic wait_drain();
      drive_idle();
      drive_idle();
      while ((req_q.size() > 0) || (resp_q.size() > 0) || !lumi_rx_top_i.fifo_empty)
         drive_idle();
   endtask

   task automatic check_remote_credits();
      assert (rmt_crdt_req == exp_rmt_req)
      else report_mismatch("rmt_crdt_req", 160'(exp_rmt_req), 160'(rmt_crdt_req));
      assert (rmt_crdt_resp == exp_rmt_resp)
      else report_mismatch("rmt_crdt_resp", 160'(exp_rmt_resp), 160'(rmt_crdt_resp));
   endtask

   //###################################################################
   // Ready patterns, scoreboard and timeout
   //###################################################################
   always @(posedge clk)
   begin
      #10;
      if (ready_mode)
      begin
         ready_state = xorshift32(ready_state);
         req_ready   = |ready_state[1:0];  // High about three cycles in four
         resp_ready  = |ready_state[3:2];
      end
      else
      begin
         req_ready  = 1'b1;
         resp_ready = 1'b1;
      end
   end

   // Sampled mid cycle, transfer happens on next rising edge
   always @(negedge clk)
      if (nreset && req_valid && req_ready)
      begin
         assert (req_q.size() > 0)
         else report_error("request packet came out with none expected");
         if (req_q.size() > 0)
         begin
            exp_req = req_q.pop_front();
            assert (req_out == exp_req)
            else report_mismatch("req_out", exp_req, req_out);
         end
      end

   always @(negedge clk)
      if (nreset && resp_valid && resp_ready)
      begin
         assert (resp_q.size() > 0)
         else report_error("response packet came out with none expected");
         if (resp_q.size() > 0)
         begin
            exp_resp = resp_q.pop_front();
            assert (resp_out == exp_resp)
            else report_mismatch("resp_out", exp_resp, resp_out);
         end
      end

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("Timeout, traffic did not drain within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   //###################################################################
   // Test sequence
   //###################################################################
   initial
   begin
      clk          = 1'b0;
      nreset       = 1'b0;
      csr_en       = 1'b0;
      crdt_init    = CRDT_START;
      phy_rxdata   = '0;
      phy_rxvld    = 1'b0;
      req_ready    = 1'b1;
      resp_ready   = 1'b1;
      ready_mode   = 1'b0;
      beats_sent   = 0;
      cycle_cnt    = 0;
      exp_rmt_req  = '0;
      exp_rmt_resp = '0;
      stim_state   = 32'd67367;
      ready_state  = xorshift32(32'd67367);
      test_name    = "reset";
      repeat (16) @(posedge clk);
      #10;
      nreset = 1'b1;
      repeat (4) drive_idle();             // Local credits load while disabled
      csr_en = 1'b1;

      test_name = "write_req_len";
      for (int len = 0; len < 4; len++)
         repeat (2) send_umi(OPC_WRITE_REQ, 2'(len));
      wait_drain();

      test_name = "read_write_mix";
      repeat (3)
      begin
         send_umi(OPC_READ_REQ, 2'(stim_rand()));
         send_umi(OPC_WRITE_RESP, 2'(stim_rand()));
         send_umi(OPC_READ_RESP, 2'(stim_rand()));
      end
      wait_drain();

      test_name  = "backpressure";
      ready_mode = 1'b1;
      repeat (40)
      begin
         pick = stim_rand();
         case (pick[1:0])
            2'd0:    send_umi(OPC_WRITE_REQ, pick[3:2]);
            2'd1:    send_umi(OPC_READ_REQ, pick[3:2]);
            2'd2:    send_umi(OPC_READ_RESP, pick[3:2]);
            default: send_umi(OPC_WRITE_RESP, pick[3:2]);
         endcase
      end
      wait_drain();
      ready_mode = 1'b0;

      test_name = "link_credit";
      send_link(CRDT_SEL_REQ, 16'(stim_rand()));
      send_link(4'd3, 16'(stim_rand()));   // Unknown selector, no effect
      wait_drain();
      check_remote_credits();
      send_link(CRDT_SEL_RESP, 16'(stim_rand()));
      wait_drain();
      check_remote_credits();

      test_name = "invalid_opcode";
      repeat (4) send_invalid();
      wait_drain();
      check_remote_credits();

      test_name = "local_credit";
      assert (int'(loc_crdt) == int'(CRDT_START) + beats_sent)
      else report_mismatch("loc_crdt", 160'(int'(CRDT_START) + beats_sent), 160'(loc_crdt));
      assert (!req_valid && !resp_valid)
      else report_error("output valid still high after all traffic drained");

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
logic/lumi_cfg_pkg.sv
logic/lumi_cmd_pkg.sv
logic/link_framer.sv
logic/rx_beat_fifo.sv
logic/packet_assembler.sv
logic/lumi_rx_top.sv
verif/lumi_rx_assertions.sv
verif/lumi_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the link receiver testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module lumi_rx_tb -f verilog.f -o Vlumi_rx_tb
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vlumi_rx_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
   echo "Simulation reported failure, see $LOG"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status, see $LOG"
   exit 1
fi
echo "Simulation finished without failure"
exit 0
